// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module dl_fpu_tb -f src.f -o sim_dl_fpu

./obj_dir/sim_dl_fpu +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
   echo "simulation failed"
   exit 1
fi
echo "simulation passed"

// File: src.f
+incdir+verilog
verilog/dl_pkg.sv
verilog/dl_operand_if.sv
verilog/dl_add_sub.sv
verilog/dl_mul.sv
verilog/dl_sign_cmp.sv
verilog/dl_round_out.sv
verilog/dl_fpu_top.sv
testbench/dl_fpu_checker.sv
testbench/dl_fpu_tb.sv

// File: testbench/dl_fpu_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "dl_defs.svh"

module dl_fpu_checker (
   input logic               clk,
   input logic               rst_n,
   input dl_pkg::dl_opcode_t opcode,
   input logic               sub,
   input dl_pkg::dl_sinj_e   sinj_sel,
   input dl_pkg::dl_cmp_e    cmp_sel,
   input dl_pkg::dl_float_t  op_a,
   input dl_pkg::dl_float_t  op_b,
   input dl_pkg::dl_float_t  result,
   input dl_pkg::dl_flags_t  flags
);

   dl_pkg::dl_float_t expect_val;
   dl_pkg::dl_flags_t expect_flags;
   logic              hit;             // operands fall in a checked case
   int                esum;
   int                ka, kb;          // signed ordering keys
   int                err_count = 0;

   always_comb begin
      esum = int'(op_a.exp) + int'(op_b.exp);
      ka   = op_a.sign ? -int'({op_a.exp, op_a.mant}) : int'({op_a.exp, op_a.mant});
      kb   = op_b.sign ? -int'({op_b.exp, op_b.mant}) : int'({op_b.exp, op_b.mant});
      hit          = 1'b0;
      expect_val   = '0;
      expect_flags = '0;
      if (opcode == `DL_OP_MUL && op_a == 16'h3E00 && op_b.exp inside {[1:62]}) begin
         hit        = 1'b1;
         expect_val = op_b;            // 1.0 leaves b untouched
      end else if (opcode == `DL_OP_MUL && op_a.exp inside {[1:62]}
                   && op_b.exp inside {[1:62]}) begin
         if (esum > 94) begin
            hit                   = 1'b1;
            expect_val            = (op_a.sign ^ op_b.sign) ? `DL_MAX_NEG : `DL_MAX_POS;
            expect_flags.overflow = 1'b1;
         end else if (esum <= `DL_BIAS) begin
            hit                    = 1'b1;
            expect_flags.underflow = 1'b1;
         end
      end else if (opcode == `DL_OP_ADD_SUB && op_a == op_b && op_a.exp inside {[1:61]}) begin
         hit = 1'b1;
         if (!sub)
            expect_val = {op_a.sign, op_a.exp + 6'd1, op_a.mant};
      end else if (opcode == `DL_OP_SIGN) begin
         hit        = 1'b1;
         expect_val = op_b;
         case (sinj_sel)
            dl_pkg::SINJ_COPY: expect_val.sign = op_a.sign;
            dl_pkg::SINJ_XOR:  expect_val.sign = op_a.sign ^ op_b.sign;
            default:           expect_val.sign = ~op_a.sign;
         endcase
      end else if (opcode == `DL_OP_CMP && cmp_sel inside {[1:5]}) begin
         hit = 1'b1;
         case (cmp_sel)
            dl_pkg::CMP_MIN: expect_val = (ka < kb) ? op_a : op_b;
            dl_pkg::CMP_MAX: expect_val = (ka > kb) ? op_a : op_b;
            dl_pkg::CMP_EQ:  expect_val = {16{op_a == op_b}};
            dl_pkg::CMP_LT:  expect_val = {16{ka < kb}};
            default:         expect_val = {16{ka <= kb}};
         endcase
      end
   end

   // output is clear while in reset and one cycle after
   reset_clear: assert property (@(posedge clk)
         !rst_n || $rose(rst_n) |-> result == '0 && flags == '0)
      else begin
         err_count++;
         $error("Mismatch at %0t: result %h flags %b, expected all zero around reset",
                $time, $sampled(result), $sampled(flags));
      end

   result_match: assert property (@(posedge clk) disable iff (!rst_n)
         $past(hit, 2) |-> result == $past(expect_val, 2))
      else begin
         err_count++;
         $error("Mismatch at %0t: result got %h expected %h",
                $time, $sampled(result), $past(expect_val, 2));
      end

   flags_match: assert property (@(posedge clk) disable iff (!rst_n)
         $past(hit, 2) |-> flags == $past(expect_flags, 2))
      else begin
         err_count++;
         $error("Mismatch at %0t: flags got %b expected %b",
                $time, $sampled(flags), $past(expect_flags, 2));
      end

endmodule

`default_nettype wire

// File: testbench/dl_fpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "dl_defs.svh"

module dl_fpu_tb;

   localparam int CLK_PERIOD   = 40;
   localparam int RESET_CYCLES = 16;
   localparam int TEST_CYCLES  = 200;
   localparam int NUM_TESTS    = 6;
   localparam int TIMEOUT_NS   = (TEST_CYCLES * NUM_TESTS + RESET_CYCLES + 20) * CLK_PERIOD;

   logic               clk;
   logic               rst_n;
   dl_pkg::dl_opcode_t opcode;
   dl_pkg::dl_rm_e     rm;
   logic               sub;
   dl_pkg::dl_sinj_e   sinj_sel;
   dl_pkg::dl_cmp_e    cmp_sel;
   dl_pkg::dl_float_t  op_a, op_b;
   dl_pkg::dl_float_t  result;
   logic               invalid, inexact, overflow, underflow, div_by_zero;

   dl_fpu_top uut (.*);

   bind dl_fpu_top dl_fpu_checker u_chk (
      .clk      (clk),
      .rst_n    (rst_n),
      .opcode   (opcode),
      .sub      (sub),
      .sinj_sel (sinj_sel),
      .cmp_sel  (cmp_sel),
      .op_a     (op_a),
      .op_b     (op_b),
      .result   (result),
      .flags    ({invalid, inexact, overflow, underflow, div_by_zero})
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // random normal value with exponent in [lo, hi]
   function automatic dl_pkg::dl_float_t rand_normal(int lo, int hi);
      dl_pkg::dl_float_t v;
      v.sign = 1'($urandom);
      v.exp  = 6'(lo + int'($urandom % (hi - lo + 1)));
      v.mant = 9'($urandom);
      return v;
   endfunction

   // one operation per clock with random controls
   task automatic apply_op(dl_pkg::dl_opcode_t op, dl_pkg::dl_float_t a, dl_pkg::dl_float_t b);
      @(posedge clk);
      opcode   <= op;
      op_a     <= a;
      op_b     <= b;
      rm       <= dl_pkg::dl_rm_e'(3'($urandom % 4));
      sub      <= 1'($urandom);
      sinj_sel <= dl_pkg::dl_sinj_e'(2'($urandom));
      cmp_sel  <= dl_pkg::dl_cmp_e'(3'($urandom % 5 + 1));
   endtask

   initial begin
      dl_pkg::dl_float_t a;
      void'($urandom(32'h7b2a4b31));
      rst_n    = 1'b0;
      opcode   = '0;
      rm       = dl_pkg::RM_NEAREST_EVEN;
      sub      = 1'b0;
      sinj_sel = dl_pkg::SINJ_INV;
      cmp_sel  = dl_pkg::CMP_MIN;
      op_a     = '0;
      op_b     = '0;
      repeat (RESET_CYCLES) @(posedge clk);
      rst_n <= 1'b1;
      @(posedge clk);                  // idle cycle right after reset
      for (int i = 0; i < TEST_CYCLES; i++)
         apply_op(`DL_OP_MUL, 16'h3E00, rand_normal(2, 60));
      for (int i = 0; i < TEST_CYCLES; i++) begin
         a = rand_normal(2, 60);
         apply_op(`DL_OP_ADD_SUB, a, a);   // doubling or cancel by sub
      end
      for (int i = 0; i < TEST_CYCLES; i++)
         apply_op(`DL_OP_SIGN, rand_normal(2, 60), rand_normal(2, 60));
      for (int i = 0; i < TEST_CYCLES; i++) begin
         a = rand_normal(2, 60);
         apply_op(`DL_OP_CMP, a, ($urandom % 4 == 0) ? a : rand_normal(2, 60));
      end
      for (int i = 0; i < TEST_CYCLES; i++) begin
         if (i % 2 == 1)
            apply_op(`DL_OP_MUL, rand_normal(48, 60), rand_normal(48, 60));
         else
            apply_op(`DL_OP_MUL, rand_normal(2, 14), rand_normal(2, 14));
      end
      apply_op('0, '0, '0);
      repeat (4) @(posedge clk);       // drain the pipeline
      @(negedge clk);
      if (uut.u_chk.err_count == 0) begin
         $display("** PASS **");
         $finish;
      end else begin
         $display("** FAIL **");
         $fatal(1, "checker assertions failed");
      end
   end

   always @(negedge clk) begin
      if (uut.u_chk.err_count != 0) begin
         $display("** FAIL **");
         $fatal(1, "checker assertion failed, stopping at first error");
      end
   end

   initial begin
      #(TIMEOUT_NS);
      $display("** FAIL **");
      $fatal(1, "watchdog timeout, stimulus did not finish in time");
   end

endmodule

`default_nettype wire

// File: verilog/dl_add_sub.sv
`timescale 1ns/1ps
`default_nettype none

`include "dl_defs.svh"

module dl_add_sub (
   dl_operand_if.unit        ops,
   output dl_pkg::dl_ext_t   sum,
   output dl_pkg::dl_flags_t flags
);

   logic        sa, sb;          // effective signs
   logic [5:0]  ea, eb;
   logic [9:0]  ma, mb;          // hidden bit included
   logic        a_big;           // |a| >= |b|
   logic [5:0]  big_exp;
   logic [5:0]  shift;
   logic [9:0]  big_m, small_m;
   logic [23:0] small_sh;
   logic        sticky;
   logic [13:0] big_x, small_x;
   logic [14:0] raw;
   logic [3:0]  lz;
   logic [13:0] norm;
   logic [7:0]  exp_res;         // bit 7 set means negative
   logic        res_sign;
   logic        is_nan;

   always_comb begin
      sa = ops.src_a.sign;
      sb = ops.src_b.sign ^ ops.sub;
      ea = ops.src_a.exp;
      eb = ops.src_b.exp;
      // zero exponent counts as zero
      ma = (ea == '0) ? 10'd0 : {1'b1, ops.src_a.mant};
      mb = (eb == '0) ? 10'd0 : {1'b1, ops.src_b.mant};
      is_nan = (ops.src_a == `DL_NAN) || (ops.src_b == `DL_NAN);

      a_big = {ea, ops.src_a.mant} >= {eb, ops.src_b.mant};
      if (a_big) begin
         big_exp = ea;
         shift   = ea - eb;
         big_m   = ma;
         small_m = mb;
      end else begin
         big_exp = eb;
         shift   = eb - ea;
         big_m   = mb;
         small_m = ma;
      end

      // align smaller operand, keep lost bits as sticky
      small_sh = {small_m, 14'd0} >> shift;
      sticky   = (|small_sh[9:0]) | ((shift > 6'd23) & (|small_m));
      small_x  = {small_sh[23:11], small_sh[10] | sticky};
      big_x    = {big_m, 4'd0};

      if (sa == sb)
         raw = {1'b0, big_x} + {1'b0, small_x};
      else
         raw = {1'b0, big_x} - {1'b0, small_x};

      // larger magnitude decides the sign
      if (sa == sb)
         res_sign = sa;
      else
         res_sign = a_big ? sa : sb;

      // leading one search
      lz = 4'd0;
      for (int i = 0; i < 14; i++) begin
         if (raw[i])
            lz = 4'(13 - i);   // highest set bit wins
      end

      if (raw[14]) begin
         norm    = {raw[14:2], raw[1] | raw[0]};
         exp_res = {2'b00, big_exp} + 8'd1;
      end else begin
         norm    = raw[13:0] << lz;
         exp_res = {2'b00, big_exp} - {4'd0, lz};
      end

      sum   = '0;
      flags = '0;
      if (ops.opcode == `DL_OP_ADD_SUB) begin
         if (is_nan) begin
            sum.val = `DL_NAN;
         end else if (raw == '0) begin
            sum = '0;                                // exact cancellation
         end else if (!exp_res[7] && exp_res >= 8'(`DL_EXP_MAX)) begin
            flags.overflow = 1'b1;
            sum.val = res_sign ? `DL_MAX_NEG : `DL_MAX_POS;
         end else if (exp_res[7]) begin
            flags.underflow = 1'b1;
            sum.val = res_sign ? `DL_MIN_NEG : `DL_MIN_POS;
         end else if (exp_res == 8'd0) begin
            flags.underflow = 1'b1;                  // flush to zero
         end else begin
            sum.val = {res_sign, exp_res[5:0], norm[12:4]};
            sum.grs = norm[3:0];
         end
         flags.inexact = |sum.grs;
      end
   end

endmodule

`default_nettype wire

// File: verilog/dl_defs.svh
`ifndef DL_DEFS_SVH
`define DL_DEFS_SVH

// DLFloat16 field widths: 1 sign, 6 exponent, 9 mantissa
`define DL_EXP_W   6
`define DL_MANT_W  9
`define DL_GRS_W   4   // guard, round and two sticky bits
`define DL_BIAS    31
`define DL_EXP_MAX 63

// saturation and special values
`define DL_MAX_POS 16'h7DFE
`define DL_MAX_NEG 16'hFDFE
`define DL_MIN_POS 16'h0201
`define DL_MIN_NEG 16'h8201
`define DL_NAN     16'hFFFF

// unit opcodes
`define DL_OP_ADD_SUB 4'd1
`define DL_OP_MUL     4'd2
`define DL_OP_SIGN    4'd5
`define DL_OP_CMP     4'd6

`endif

// File: verilog/dl_fpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module dl_fpu_top (
   input  logic               clk,
   input  logic               rst_n,
   input  dl_pkg::dl_opcode_t opcode,
   input  dl_pkg::dl_rm_e     rm,
   input  logic               sub,
   input  dl_pkg::dl_sinj_e   sinj_sel,
   input  dl_pkg::dl_cmp_e    cmp_sel,
   input  dl_pkg::dl_float_t  op_a,
   input  dl_pkg::dl_float_t  op_b,
   output dl_pkg::dl_float_t  result,
   output logic               invalid,
   output logic               inexact,
   output logic               overflow,
   output logic               underflow,
   output logic               div_by_zero
);

   dl_operand_if ops ();

   dl_pkg::dl_rm_e    rm_q;        // travels with the operands
   dl_pkg::dl_ext_t   sum, product, value;
   dl_pkg::dl_flags_t add_flags, mul_flags;
   dl_pkg::dl_flags_t flags;

   // input stage, opcode 0 selects no unit after reset
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ops.opcode   <= '0;
         ops.src_a    <= '0;
         ops.src_b    <= '0;
         ops.sub      <= 1'b0;
         ops.sinj_sel <= dl_pkg::SINJ_INV;
         ops.cmp_sel  <= dl_pkg::dl_cmp_e'(3'd0);
         rm_q         <= dl_pkg::RM_NEAREST_EVEN;
      end else begin
         ops.opcode   <= opcode;
         ops.src_a    <= op_a;
         ops.src_b    <= op_b;
         ops.sub      <= sub;
         ops.sinj_sel <= sinj_sel;
         ops.cmp_sel  <= cmp_sel;
         rm_q         <= rm;
      end
   end

   dl_add_sub u_add_sub (
      .ops   (ops.unit),
      .sum   (sum),
      .flags (add_flags)
   );

   dl_mul u_mul (
      .ops     (ops.unit),
      .product (product),
      .flags   (mul_flags)
   );

   dl_sign_cmp u_sign_cmp (
      .ops   (ops.unit),
      .value (value)
   );

   dl_round_out u_round_out (
      .clk       (clk),
      .rst_n     (rst_n),
      .opcode    (ops.opcode),
      .rm        (rm_q),
      .sum       (sum),
      .product   (product),
      .value     (value),
      .add_flags (add_flags),
      .mul_flags (mul_flags),
      .result    (result),
      .flags     (flags)
   );

   assign invalid     = flags.invalid;
   assign inexact     = flags.inexact;
   assign overflow    = flags.overflow;
   assign underflow   = flags.underflow;
   assign div_by_zero = flags.div_zero;   // no divider, stays low

endmodule

`default_nettype wire

// File: verilog/dl_mul.sv
`timescale 1ns/1ps
`default_nettype none

`include "dl_defs.svh"

module dl_mul (
   dl_operand_if.unit        ops,
   output dl_pkg::dl_ext_t   product,
   output dl_pkg::dl_flags_t flags
);

   logic [6:0]  esum;
   logic [5:0]  e_base;
   logic [19:0] prod;
   logic        sign;

   always_comb begin
      esum   = {1'b0, ops.src_a.exp} + {1'b0, ops.src_b.exp};
      e_base = 6'(esum - 7'(`DL_BIAS));
      prod   = {1'b1, ops.src_a.mant} * {1'b1, ops.src_b.mant};
      sign   = ops.src_a.sign ^ ops.src_b.sign;

      product = '0;
      flags   = '0;
      if (ops.opcode == `DL_OP_MUL) begin
         if ((ops.src_a == `DL_NAN) || (ops.src_b == `DL_NAN)) begin
            product.val = `DL_NAN;
         end else if (ops.src_a.exp == '0 || ops.src_b.exp == '0) begin
            product = '0;                            // zero operand
         end else if (esum <= 7'(`DL_BIAS)) begin
            flags.underflow = 1'b1;
         end else if (esum > 7'(`DL_EXP_MAX + `DL_BIAS)) begin
            flags.overflow = 1'b1;
            product.val = sign ? `DL_MAX_NEG : `DL_MAX_POS;
         end else if (esum == 7'(`DL_EXP_MAX + `DL_BIAS)) begin
            flags.invalid = 1'b1;
            product.val = `DL_NAN;
         end else if (prod[19]) begin
            // 1x.xxx product, renormalize
            product.val = {sign, e_base + 6'd1, prod[18:10]};
            product.grs = {prod[9:7], |prod[6:0]};
         end else begin
            product.val = {sign, e_base, prod[17:9]};
            product.grs = {prod[8:6], |prod[5:0]};
         end
         flags.inexact = |product.grs;
      end
   end

endmodule

`default_nettype wire

// File: verilog/dl_operand_if.sv
`timescale 1ns/1ps
`default_nettype none

// registered operands and controls, shared by the arithmetic units
interface dl_operand_if;

   dl_pkg::dl_opcode_t opcode;
   dl_pkg::dl_float_t  src_a;
   dl_pkg::dl_float_t  src_b;
   logic               sub;        // b is negated before the add
   dl_pkg::dl_sinj_e   sinj_sel;
   dl_pkg::dl_cmp_e    cmp_sel;

   modport issue (output opcode, src_a, src_b, sub, sinj_sel, cmp_sel);
   modport unit  (input  opcode, src_a, src_b, sub, sinj_sel, cmp_sel);

endinterface

`default_nettype wire

// File: verilog/dl_pkg.sv
`default_nettype none

`include "dl_defs.svh"

package dl_pkg;

   typedef struct packed {
      logic                  sign;
      logic [`DL_EXP_W-1:0]  exp;
      logic [`DL_MANT_W-1:0] mant;
   } dl_float_t;

   // unit result before rounding
   typedef struct packed {
      dl_float_t            val;
      logic [`DL_GRS_W-1:0] grs;   // [3] is the guard bit
   } dl_ext_t;

   typedef struct packed {
      logic invalid;
      logic inexact;
      logic overflow;
      logic underflow;
      logic div_zero;
   } dl_flags_t;

   typedef logic [3:0] dl_opcode_t;

   typedef enum logic [2:0] {
      RM_NEAREST_EVEN = 3'd0,
      RM_ZERO         = 3'd1,
      RM_UP           = 3'd2,
      RM_DOWN         = 3'd3
   } dl_rm_e;

   typedef enum logic [1:0] {
      SINJ_INV  = 2'd0,
      SINJ_COPY = 2'd1,
      SINJ_INV2 = 2'd2,
      SINJ_XOR  = 2'd3
   } dl_sinj_e;

   typedef enum logic [2:0] {
      CMP_MIN = 3'd1,
      CMP_MAX = 3'd2,
      CMP_EQ  = 3'd3,
      CMP_LT  = 3'd4,
      CMP_LE  = 3'd5
   } dl_cmp_e;

endpackage

`default_nettype wire

// File: verilog/dl_round_out.sv
`timescale 1ns/1ps
`default_nettype none

`include "dl_defs.svh"

module dl_round_out (
   input  logic               clk,
   input  logic               rst_n,
   input  dl_pkg::dl_opcode_t opcode,
   input  dl_pkg::dl_rm_e     rm,
   input  dl_pkg::dl_ext_t    sum,
   input  dl_pkg::dl_ext_t    product,
   input  dl_pkg::dl_ext_t    value,
   input  dl_pkg::dl_flags_t  add_flags,
   input  dl_pkg::dl_flags_t  mul_flags,
   output dl_pkg::dl_float_t  result,
   output dl_pkg::dl_flags_t  flags
);

   dl_pkg::dl_ext_t   pick;
   dl_pkg::dl_flags_t pick_flags;
   dl_pkg::dl_float_t rounded;
   logic              g_bit;
   logic              rs_bit;      // round or sticky
   logic              any_grs;
   logic              up;
   logic [9:0]        mant_inc;

   // unit select, units already zero themselves when idle
   always_comb begin
      case (opcode)
         `DL_OP_ADD_SUB: begin
            pick       = sum;
            pick_flags = add_flags;
         end
         `DL_OP_MUL: begin
            pick       = product;
            pick_flags = mul_flags;
         end
         `DL_OP_SIGN, `DL_OP_CMP: begin
            pick       = value;
            pick_flags = '0;       // sign and compare never flag
         end
         default: begin
            pick       = '0;
            pick_flags = '0;
         end
      endcase
   end

   always_comb begin
      g_bit   = pick.grs[3];
      rs_bit  = |pick.grs[2:0];
      any_grs = |pick.grs;

      case (rm)
         dl_pkg::RM_NEAREST_EVEN: up = g_bit & (rs_bit | pick.val.mant[0]);
         dl_pkg::RM_ZERO:         up = 1'b0;                  // truncate
         dl_pkg::RM_UP:           up = any_grs & ~pick.val.sign;
         dl_pkg::RM_DOWN:         up = any_grs & pick.val.sign;
         default:                 up = 1'b0;
      endcase

      mant_inc     = {1'b0, pick.val.mant} + {9'd0, up};
      rounded.sign = pick.val.sign;
      rounded.mant = mant_inc[8:0];
      rounded.exp  = pick.val.exp + {5'd0, mant_inc[9]};   // mantissa carry
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         result <= '0;
         flags  <= '0;
      end else begin
         result <= rounded;
         flags  <= pick_flags;
      end
   end

endmodule

`default_nettype wire

// File: verilog/dl_sign_cmp.sv
`timescale 1ns/1ps
`default_nettype none

`include "dl_defs.svh"

module dl_sign_cmp (
   dl_operand_if.unit      ops,
   output dl_pkg::dl_ext_t value
);

   logic sa, sb;
   logic lt, gt, eq;
   logic inj_sign;

   always_comb begin
      sa = ops.src_a.sign;
      sb = ops.src_b.sign;

      // order by sign, then exponent, then mantissa
      lt = 1'b0;
      gt = 1'b0;
      eq = 1'b0;
      if (sa != sb) begin
         lt = sa;
         gt = sb;
      end else if (ops.src_a.exp != ops.src_b.exp) begin
         gt = (ops.src_a.exp > ops.src_b.exp) ^ sa;   // negative flips order
         lt = ~gt;
      end else if (ops.src_a.mant != ops.src_b.mant) begin
         gt = (ops.src_a.mant > ops.src_b.mant) ^ sa;
         lt = ~gt;
      end else begin
         eq = 1'b1;
      end

      case (ops.sinj_sel)
         dl_pkg::SINJ_INV:  inj_sign = ~sa;
         dl_pkg::SINJ_COPY: inj_sign = sa;
         dl_pkg::SINJ_INV2: inj_sign = ~sa;
         default:           inj_sign = sa ^ sb;
      endcase

      value = '0;   // grs always zero here
      if (ops.opcode == `DL_OP_SIGN) begin
         value.val = {inj_sign, ops.src_b.exp, ops.src_b.mant};
      end else if (ops.opcode == `DL_OP_CMP) begin
         case (ops.cmp_sel)
            dl_pkg::CMP_MIN: value.val = lt ? ops.src_a : ops.src_b;
            dl_pkg::CMP_MAX: value.val = gt ? ops.src_a : ops.src_b;
            dl_pkg::CMP_EQ:  value.val = {16{eq}};
            dl_pkg::CMP_LT:  value.val = {16{lt}};
            dl_pkg::CMP_LE:  value.val = {16{lt | eq}};
            default:         value.val = '0;
         endcase
      end
   end

endmodule

`default_nettype wire
